/* tb.f */
verilog/core_pkg.sv
verilog/core_cfg_regs.sv
verilog/fetch_unit.sv
verilog/fetch_queue_rolly.sv
verilog/cmd_fifo.sv
verilog/exec_unit.sv
verilog/core_top.sv
testbench/core_top_asserts.sv
testbench/tb_core_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module tb_core_top \
    -f tb.f -o sim_core && ./obj_dir/sim_core; } > sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

/* testbench/tb_core_top.sv */
// Imem model keeps one request in flight with 1 to 3 cycles latency; only the first 42 commits are checked
`timescale 1ns/100ps
`default_nettype none

module tb_core_top
    import core_pkg::*;
();

    localparam int n_exp_c = 42;                      // 6 lead-in commits, then 4 loop passes
    localparam int prog_len_c = 16;
    localparam int cfg_n_c = 3;
    localparam logic [15:0] boot_pc_c = 16'd0;
    localparam logic [15:0] trap_pc_c = 16'd32;

    logic        clk;
    logic        rst_n;
    logic        cfg_we;
    cfg_addr_t   cfg_addr;
    logic [15:0] cfg_wdata;
    logic [15:0] imem_addr;
    logic        imem_valid;
    logic        imem_ready;
    logic [31:0] imem_rdata;
    logic        imem_err;
    logic        imem_rvalid;
    logic        cmt_valid;
    logic        cmt_ready;
    logic [15:0] cmt_pc;
    logic        cmt_rd_w_v;
    logic [2:0]  cmt_rd_addr;
    logic [31:0] cmt_data;
    logic        cmt_exc;

    logic [31:0] prog [prog_len_c];
    logic [31:0] trap_word;
    cfg_addr_t   cfg_tab_addr [cfg_n_c];
    logic [15:0] cfg_tab_data [cfg_n_c];
    logic [15:0] exp_pc [n_exp_c];
    logic        exp_w [n_exp_c];
    logic [2:0]  exp_rd [n_exp_c];
    logic [31:0] exp_data [n_exp_c];
    logic        exp_exc [n_exp_c];

    logic [31:0] lcg_state;
    logic        en_written;
    logic        mem_busy;
    int          mem_lat;
    logic        req_acc;
    logic [15:0] req_addr;
    int          cmt_idx;

    core_top #(.fq_els_p(8), .cmd_els_p(2)) i_core_top (
        .clk_i(clk), .rst_n_i(rst_n),
        .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
        .imem_addr_o(imem_addr), .imem_valid_o(imem_valid), .imem_ready_i(imem_ready),
        .imem_rdata_i(imem_rdata), .imem_err_i(imem_err), .imem_rvalid_i(imem_rvalid),
        .cmt_valid_o(cmt_valid), .cmt_ready_i(cmt_ready), .cmt_pc_o(cmt_pc),
        .cmt_rd_w_v_o(cmt_rd_w_v), .cmt_rd_addr_o(cmt_rd_addr), .cmt_data_o(cmt_data),
        .cmt_exc_o(cmt_exc)
    );

    bind core_top core_top_asserts i_asserts (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .cmt_valid_i(cmt_valid_o), .cmt_ready_i(cmt_ready_i), .cmt_pc_i(cmt_pc_o),
        .cmt_rd_w_v_i(cmt_rd_w_v_o), .cmt_rd_addr_i(cmt_rd_addr_o),
        .cmt_data_i(cmt_data_o), .cmt_exc_i(cmt_exc_o),
        .fq_yumi_i(fq_yumi), .fq_out_valid_i(fq_out_valid),
        .fq_clr_i(fq_clr), .fq_roll_i(fq_roll)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] enc(input logic [1:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [15:0] imm);
        return {op, rd, rs, 8'h00, imm};
    endfunction

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic mem_hit(input logic [15:0] a);
        return a < 16'(prog_len_c) || a == trap_pc_c;
    endfunction

    function automatic logic [31:0] mem_word(input logic [15:0] a);
        return (a == trap_pc_c) ? trap_word : prog[a[3:0]];
    endfunction

    task fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on failure");
    endtask

    task check_field(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0d ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    task build_tables;
        prog[0]  = enc(op_addi_c, 3'd1, 3'd0, 16'd5);
        prog[1]  = enc(op_addi_c, 3'd2, 3'd1, 16'd3);    // Depends on the previous word
        prog[2]  = enc(op_addi_c, 3'd2, 3'd2, 16'hffff);
        prog[3]  = enc(op_addi_c, 3'd0, 3'd1, 16'd7);    // r0 must stay zero
        prog[4]  = enc(op_addi_c, 3'd3, 3'd0, 16'd1);
        prog[5]  = enc(op_jmp_c,  3'd0, 3'd0, 16'd8);    // Forward jump
        prog[6]  = enc(op_addi_c, 3'd4, 3'd4, 16'd100);  // Wrong path
        prog[7]  = enc(op_nop_c,  3'd0, 3'd0, 16'd0);
        prog[8]  = enc(op_addi_c, 3'd5, 3'd5, 16'd1);    // Loop counter
        prog[9]  = enc(op_nop_c,  3'd0, 3'd0, 16'd0);
        prog[10] = enc(op_addi_c, 3'd6, 3'd5, 16'd16);
        prog[11] = enc(op_jmp_c,  3'd0, 3'd0, 16'd13);
        prog[12] = enc(op_addi_c, 3'd7, 3'd7, 16'd1);    // Wrong path
        prog[13] = enc(op_addi_c, 3'd7, 3'd7, 16'd2);
        prog[14] = enc(op_nop_c,  3'd0, 3'd0, 16'd0);
        prog[15] = enc(op_addi_c, 3'd4, 3'd4, 16'hfff0); // Next fetch falls off the table
        trap_word = enc(op_jmp_c, 3'd0, 3'd0, 16'd8);     // Backward jump into the loop
        cfg_tab_addr[0] = cfg_boot_pc_c;
        cfg_tab_data[0] = boot_pc_c;
        cfg_tab_addr[1] = cfg_trap_pc_c;
        cfg_tab_data[1] = trap_pc_c;
        cfg_tab_addr[2] = cfg_enable_c;
        cfg_tab_data[2] = 16'd1;
    endtask

    // Reference model of the ISA, one entry per commit
    task build_expected;
        logic [15:0] pc;
        logic [31:0] regs [8];
        logic [31:0] w;
        logic [31:0] val;
        pc = boot_pc_c;
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        for (int n = 0; n < n_exp_c; n++) begin
            exp_pc[n]   = pc;
            exp_w[n]    = 1'b0;
            exp_rd[n]   = '0;
            exp_data[n] = '0;
            exp_exc[n]  = 1'b0;
            if (!mem_hit(pc)) begin
                exp_exc[n]  = 1'b1;
                exp_data[n] = 32'd1;                       // Fetch error cause
                pc = trap_pc_c;
            end else begin
                w = mem_word(pc);
                if (w[31:30] == op_addi_c) begin
                    val = (w[26:24] == 3'd0 ? 32'd0 : regs[w[26:24]])
                        + {{16{w[15]}}, w[15:0]};
                    exp_w[n]    = 1'b1;
                    exp_rd[n]   = w[29:27];
                    exp_data[n] = val;
                    if (w[29:27] != 3'd0)
                        regs[w[29:27]] = val;
                    pc = pc + 16'd1;
                end else if (w[31:30] == op_jmp_c) begin
                    pc = w[15:0];
                end else begin
                    pc = pc + 16'd1;
                end
            end
        end
    endtask

    task check_commit(input int idx);
        check_field($sformatf("commit %0d pc", idx), 32'(cmt_pc), 32'(exp_pc[idx]));
        check_field($sformatf("commit %0d exc flag", idx), 32'(cmt_exc), 32'(exp_exc[idx]));
        check_field($sformatf("commit %0d write flag", idx), 32'(cmt_rd_w_v), 32'(exp_w[idx]));
        if (exp_w[idx])
            check_field($sformatf("commit %0d rd", idx), 32'(cmt_rd_addr), 32'(exp_rd[idx]));
        if (exp_w[idx] || exp_exc[idx])
            check_field($sformatf("commit %0d data", idx), cmt_data, exp_data[idx]);
    endtask

    // Imem model, commit checker and random stalls in one process
    always @(posedge clk) begin
        if (rst_n) begin
            req_acc = imem_valid && imem_ready;
            if (imem_valid && !en_written)
                fail_run("Instruction request issued while the core is disabled");
            if (req_acc && mem_busy)
                fail_run("Second instruction request accepted while one is outstanding");
            if (req_acc)
                req_addr = imem_addr;
            if (cmt_valid && cmt_ready && cmt_idx < n_exp_c) begin
                check_commit(cmt_idx);
                cmt_idx++;
            end
            #1;
            imem_rvalid = 1'b0;
            imem_err    = 1'b0;
            if (req_acc) begin
                mem_busy = 1'b1;
                mem_lat  = int'(next_rand() % 16'd3);
            end
            if (mem_busy) begin
                if (mem_lat == 0) begin
                    imem_rvalid = 1'b1;
                    imem_err    = !mem_hit(req_addr);
                    imem_rdata  = mem_hit(req_addr) ? mem_word(req_addr) : 32'hdeadbeef;
                    mem_busy    = 1'b0;
                end else begin
                    mem_lat--;
                end
            end
            imem_ready = (next_rand() % 16'd4) != 16'd0;
            cmt_ready  = (next_rand() % 16'd4) != 16'd0;
        end
    end

    initial begin
        repeat (40 * n_exp_c + 200) @(posedge clk);
        fail_run($sformatf("Timeout after %0d of %0d commits", cmt_idx, n_exp_c));
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        imem_ready = 1'b0;
        imem_rdata = '0;
        imem_err = 1'b0;
        imem_rvalid = 1'b0;
        cmt_ready = 1'b0;
        lcg_state = 32'd64592;
        en_written = 1'b0;
        mem_busy = 1'b0;
        mem_lat = 0;
        req_addr = '0;
        cmt_idx = 0;
        build_tables();
        build_expected();
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (8) @(posedge clk);                        // Disabled core must stay idle
        for (int i = 0; i < cfg_n_c; i++) begin
            @(posedge clk);
            #1;
            cfg_we    = 1'b1;
            cfg_addr  = cfg_tab_addr[i];
            cfg_wdata = cfg_tab_data[i];
            if (cfg_tab_addr[i] == cfg_enable_c)
                en_written = 1'b1;
        end
        @(posedge clk);
        #1 cfg_we = 1'b0;
        wait (cmt_idx == n_exp_c);
        repeat (4) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/core_top_asserts.sv */
// Bound into core_top; expects the internal queue nets fq_yumi, fq_out_valid, fq_clr and fq_roll
`timescale 1ns/100ps
`default_nettype none

module core_top_asserts
    import core_pkg::*;
(
    input  logic                          clk_i
    , input  logic                        rst_n_i
    , input  logic                        cmt_valid_i
    , input  logic                        cmt_ready_i
    , input  logic [pc_width_c-1:0]       cmt_pc_i
    , input  logic                        cmt_rd_w_v_i
    , input  logic [reg_addr_width_c-1:0] cmt_rd_addr_i
    , input  logic [reg_data_width_c-1:0] cmt_data_i
    , input  logic                        cmt_exc_i
    , input  logic                        fq_yumi_i
    , input  logic                        fq_out_valid_i
    , input  logic                        fq_clr_i
    , input  logic                        fq_roll_i
);

    // A stalled commit keeps its valid and its record
    property cmt_hold_p;
        @(posedge clk_i) disable iff (!rst_n_i)
            cmt_valid_i && !cmt_ready_i |=> cmt_valid_i && $stable(cmt_pc_i)
                && $stable(cmt_rd_w_v_i) && $stable(cmt_rd_addr_i)
                && $stable(cmt_data_i) && $stable(cmt_exc_i);
    endproperty

    a_cmt_hold: assert property (cmt_hold_p)
        else $error("Commit port dropped valid or changed data while stalled");

    a_yumi_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fq_yumi_i |-> fq_out_valid_i)
        else $error("Fetch queue read strobe without valid data");

    a_clr_roll: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(fq_clr_i && fq_roll_i))
        else $error("Fetch queue clear and rollback in the same cycle");

endmodule

`default_nettype wire

/* verilog/core_top.sv */
// Config writes must set boot PC and trap vector before enable; queue depths must be powers of two
`timescale 1ns/100ps
`default_nettype none

module core_top
    import core_pkg::*;
#(
    parameter int fq_els_p    = 8
    , parameter int cmd_els_p = 2
)
(
    input  logic                          clk_i
    , input  logic                        rst_n_i

    , input  logic                        cfg_we_i
    , input  cfg_addr_t                   cfg_addr_i
    , input  logic [pc_width_c-1:0]       cfg_wdata_i

    , output logic [pc_width_c-1:0]       imem_addr_o
    , output logic                        imem_valid_o
    , input  logic                        imem_ready_i
    , input  logic [instr_width_c-1:0]    imem_rdata_i
    , input  logic                        imem_err_i
    , input  logic                        imem_rvalid_i

    , output logic                        cmt_valid_o
    , input  logic                        cmt_ready_i
    , output logic [pc_width_c-1:0]       cmt_pc_o
    , output logic                        cmt_rd_w_v_o
    , output logic [reg_addr_width_c-1:0] cmt_rd_addr_o
    , output logic [reg_data_width_c-1:0] cmt_data_o
    , output logic                        cmt_exc_o
);

    logic [pc_width_c-1:0] boot_pc, trap_pc;
    logic                  core_en;
    fq_entry_t             fq_data, fq_out_data;
    logic                  fq_valid, fq_ready, fq_out_valid, fq_yumi;
    logic                  fq_clr, fq_ckpt, fq_roll;
    fe_cmd_t               be_cmd, fe_cmd;           // Back end side, front end side
    logic                  be_cmd_valid, be_cmd_ready, fe_cmd_valid, fe_cmd_ready;

    core_cfg_regs i_cfg_regs
        (.clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.cfg_we_i(cfg_we_i)
        ,.cfg_addr_i(cfg_addr_i)
        ,.cfg_wdata_i(cfg_wdata_i)
        ,.boot_pc_o(boot_pc)
        ,.trap_pc_o(trap_pc)
        ,.core_en_o(core_en)
        );

    fetch_unit i_fetch
        (.clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.boot_pc_i(boot_pc)
        ,.core_en_i(core_en)
        ,.imem_addr_o(imem_addr_o)
        ,.imem_valid_o(imem_valid_o)
        ,.imem_ready_i(imem_ready_i)
        ,.imem_rdata_i(imem_rdata_i)
        ,.imem_err_i(imem_err_i)
        ,.imem_rvalid_i(imem_rvalid_i)
        ,.fq_data_o(fq_data)
        ,.fq_valid_o(fq_valid)
        ,.fq_ready_i(fq_ready)
        ,.cmd_data_i(fe_cmd)
        ,.cmd_valid_i(fe_cmd_valid)
        ,.cmd_ready_o(fe_cmd_ready)
        );

    fetch_queue_rolly #(.els_p(fq_els_p)) i_fq
        (.clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.clr_i(fq_clr)
        ,.ckpt_i(fq_ckpt)
        ,.roll_i(fq_roll)
        ,.data_i(fq_data)
        ,.valid_i(fq_valid)
        ,.ready_o(fq_ready)
        ,.data_o(fq_out_data)
        ,.valid_o(fq_out_valid)
        ,.yumi_i(fq_yumi)
        );

    cmd_fifo #(.els_p(cmd_els_p)) i_cmd_fifo
        (.clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.data_i(be_cmd)
        ,.valid_i(be_cmd_valid)
        ,.ready_o(be_cmd_ready)
        ,.data_o(fe_cmd)
        ,.valid_o(fe_cmd_valid)
        ,.ready_i(fe_cmd_ready)
        );

    exec_unit i_exec
        (.clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.trap_pc_i(trap_pc)
        ,.fq_data_i(fq_out_data)
        ,.fq_valid_i(fq_out_valid)
        ,.fq_yumi_o(fq_yumi)
        ,.fq_clr_o(fq_clr)
        ,.fq_ckpt_o(fq_ckpt)
        ,.fq_roll_o(fq_roll)
        ,.cmd_data_o(be_cmd)
        ,.cmd_valid_o(be_cmd_valid)
        ,.cmd_ready_i(be_cmd_ready)
        ,.cmt_valid_o(cmt_valid_o)
        ,.cmt_ready_i(cmt_ready_i)
        ,.cmt_pc_o(cmt_pc_o)
        ,.cmt_rd_w_v_o(cmt_rd_w_v_o)
        ,.cmt_rd_addr_o(cmt_rd_addr_o)
        ,.cmt_data_o(cmt_data_o)
        ,.cmt_exc_o(cmt_exc_o)
        );

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
// Queue entries are checkpointed on entering stage 2; a jump or exception commits only with its redirect
`timescale 1ns/100ps
`default_nettype none

module exec_unit
    import core_pkg::*;
(
    input  logic                          clk_i
    , input  logic                        rst_n_i

    , input  logic [pc_width_c-1:0]       trap_pc_i

    , input  fq_entry_t                   fq_data_i
    , input  logic                        fq_valid_i
    , output logic                        fq_yumi_o

    , output logic                        fq_clr_o
    , output logic                        fq_ckpt_o
    , output logic                        fq_roll_o

    , output fe_cmd_t                     cmd_data_o
    , output logic                        cmd_valid_o
    , input  logic                        cmd_ready_i

    , output logic                        cmt_valid_o
    , input  logic                        cmt_ready_i
    , output logic [pc_width_c-1:0]       cmt_pc_o
    , output logic                        cmt_rd_w_v_o
    , output logic [reg_addr_width_c-1:0] cmt_rd_addr_o
    , output logic [reg_data_width_c-1:0] cmt_data_o
    , output logic                        cmt_exc_o
);

    logic [reg_data_width_c-1:0] rf [2**reg_addr_width_c];

    logic                        s1_v_r;
    fq_entry_t                   s1_r;
    logic                        s2_v_r;
    logic                        s2_redir_r;
    logic [pc_width_c-1:0]       s2_tgt_r;

    instr_t                      ins;
    logic [reg_data_width_c-1:0] rs_val;
    logic                        d_wen;
    logic                        d_redir;
    logic [reg_data_width_c-1:0] d_data;
    logic [pc_width_c-1:0]       d_tgt;
    logic                        cmt_fire;
    logic                        s1_adv;
    logic                        squash;

    assign cmt_valid_o = s2_v_r && (!s2_redir_r || cmd_ready_i);
    assign cmt_fire    = cmt_valid_o && cmt_ready_i;
    assign cmd_valid_o = s2_v_r && s2_redir_r && cmt_ready_i;
    assign cmd_data_o.pc = s2_tgt_r;
    assign fq_clr_o    = cmt_fire && s2_redir_r;     // Also flushes stage 1

    assign s1_adv    = s1_v_r && (!s2_v_r || cmt_fire) && !fq_clr_o;
    assign squash    = s1_v_r && s2_v_r && !cmt_ready_i;
    assign fq_ckpt_o = s1_adv;
    assign fq_roll_o = squash;                        // Squashed entry is read again
    assign fq_yumi_o = fq_valid_i && (!s1_v_r || s1_adv) && !fq_clr_o;

    // Stage 1 decode with forwarding from stage 2
    assign ins = s1_r.payload.instr;

    always_comb begin
        if (ins.rs == '0)
            rs_val = '0;
        else if (s2_v_r && cmt_rd_w_v_o && cmt_rd_addr_o == ins.rs)
            rs_val = cmt_data_o;
        else
            rs_val = rf[ins.rs];
    end

    always_comb begin
        d_wen   = 1'b0;
        d_redir = 1'b0;
        d_data  = '0;
        d_tgt   = ins.imm;
        if (s1_r.is_exc) begin
            d_redir = 1'b1;
            d_data  = reg_data_width_c'(s1_r.payload.exc.cause);
            d_tgt   = trap_pc_i;
        end else begin
            case (ins.op)
                op_addi_c: begin
                    d_wen  = 1'b1;
                    d_data = rs_val + {{16{ins.imm[15]}}, ins.imm};
                end
                op_jmp_c: d_redir = 1'b1;
                op_nop_c: ;
                default: ;                           // Opcode 3 runs as a no-op
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_v_r <= 1'b0;
            s2_v_r <= 1'b0;
        end else begin
            if (fq_clr_o || squash)
                s1_v_r <= 1'b0;
            else if (fq_yumi_o)
                s1_v_r <= 1'b1;
            else if (s1_adv)
                s1_v_r <= 1'b0;

            if (s1_adv)
                s2_v_r <= 1'b1;
            else if (cmt_fire)
                s2_v_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fq_yumi_o)
            s1_r <= fq_data_i;
        if (s1_adv) begin
            cmt_pc_o      <= s1_r.pc;
            cmt_rd_w_v_o  <= d_wen;
            cmt_rd_addr_o <= ins.rd;
            cmt_data_o    <= d_data;
            cmt_exc_o     <= s1_r.is_exc;
            s2_redir_r    <= d_redir;
            s2_tgt_r      <= d_tgt;
        end
    end

    // Registers start at zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**reg_addr_width_c; i++)
                rf[i] <= '0;
        end else if (cmt_fire && cmt_rd_w_v_o && cmt_rd_addr_o != '0) begin
            rf[cmt_rd_addr_o] <= cmt_data_o;
        end
    end

endmodule

`default_nettype wire

/* verilog/cmd_fifo.sv */
// Plain valid/ready FIFO for redirects; els_p must be a power of two of at least 2
`timescale 1ns/100ps
`default_nettype none

module cmd_fifo
    import core_pkg::*;
#(
    parameter int els_p = 2
)
(
    input  logic    clk_i
    , input  logic  rst_n_i

    , input  fe_cmd_t data_i
    , input  logic  valid_i
    , output logic  ready_o

    , output fe_cmd_t data_o
    , output logic  valid_o
    , input  logic  ready_i
);

    localparam int aw_lp = $clog2(els_p);

    fe_cmd_t        mem [els_p];
    logic [aw_lp:0] wptr_r;
    logic [aw_lp:0] rptr_r;
    logic           push;
    logic           pop;

    assign ready_o = (wptr_r ^ rptr_r) != {1'b1, {aw_lp{1'b0}}};
    assign valid_o = wptr_r != rptr_r;
    assign data_o  = mem[rptr_r[aw_lp-1:0]];
    assign push    = valid_i && ready_o;
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wptr_r <= '0;
            rptr_r <= '0;
        end else begin
            wptr_r <= wptr_r + (aw_lp+1)'(push);
            rptr_r <= rptr_r + (aw_lp+1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push)
            mem[wptr_r[aw_lp-1:0]] <= data_i;
    end

endmodule

`default_nettype wire

/* verilog/fetch_queue_rolly.sv */
// els_p must be a power of two; space counts from the checkpoint, clear beats rollback and checkpoint
`timescale 1ns/100ps
`default_nettype none

module fetch_queue_rolly
    import core_pkg::*;
#(
    parameter int els_p = 8
)
(
    input  logic        clk_i
    , input  logic      rst_n_i

    , input  logic      clr_i
    , input  logic      ckpt_i
    , input  logic      roll_i

    , input  fq_entry_t data_i
    , input  logic      valid_i
    , output logic      ready_o

    , output fq_entry_t data_o
    , output logic      valid_o
    , input  logic      yumi_i
);

    localparam int aw_lp = $clog2(els_p);

    fq_entry_t        mem [els_p];
    logic [aw_lp:0]   wptr_r;
    logic [aw_lp:0]   rptr_r;   // Speculative read
    logic [aw_lp:0]   cptr_r;   // Oldest entry still needed
    logic [aw_lp:0]   wptr_n;
    logic [aw_lp:0]   cptr_n;
    logic             push;

    // Full when write is a whole lap ahead of the checkpoint
    assign ready_o = (wptr_r ^ cptr_r) != {1'b1, {aw_lp{1'b0}}};
    assign push    = valid_i && ready_o;
    assign valid_o = rptr_r != wptr_r;
    assign data_o  = mem[rptr_r[aw_lp-1:0]];

    assign wptr_n = wptr_r + (aw_lp+1)'(push);
    assign cptr_n = cptr_r + (aw_lp+1)'(ckpt_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wptr_r <= '0;
            rptr_r <= '0;
            cptr_r <= '0;
        end else begin
            wptr_r <= wptr_n;
            if (clr_i) begin
                rptr_r <= wptr_n;               // Drops a same-cycle push too
                cptr_r <= wptr_n;
            end else begin
                cptr_r <= cptr_n;
                if (roll_i)
                    rptr_r <= cptr_n;
                else
                    rptr_r <= rptr_r + (aw_lp+1)'(yumi_i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push)
            mem[wptr_r[aw_lp-1:0]] <= data_i;
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
// One request in flight, PC steps by one word; fetching stops after an error until a redirect
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
    import core_pkg::*;
(
    input  logic                       clk_i
    , input  logic                     rst_n_i

    , input  logic [pc_width_c-1:0]    boot_pc_i
    , input  logic                     core_en_i

    , output logic [pc_width_c-1:0]    imem_addr_o
    , output logic                     imem_valid_o
    , input  logic                     imem_ready_i
    , input  logic [instr_width_c-1:0] imem_rdata_i
    , input  logic                     imem_err_i
    , input  logic                     imem_rvalid_i

    , output fq_entry_t                fq_data_o
    , output logic                     fq_valid_o
    , input  logic                     fq_ready_i

    , input  fe_cmd_t                  cmd_data_i
    , input  logic                     cmd_valid_i
    , output logic                     cmd_ready_o
);

    logic [pc_width_c-1:0] pc_r;   // Address of the pending or next request
    logic                  en_q_r;
    logic                  pend_r;
    logic                  halt_r;
    logic                  buf_v_r;
    fq_entry_t             buf_r;
    fq_entry_t             rsp_entry;
    logic                  cmd_take;
    logic                  rsp_v;

    // A redirect waits for the in-flight response, which it then drops
    assign cmd_ready_o = !pend_r || imem_rvalid_i;
    assign cmd_take    = cmd_valid_i && cmd_ready_o;
    assign rsp_v       = pend_r && imem_rvalid_i && !cmd_valid_i;

    assign imem_addr_o  = pc_r;
    assign imem_valid_o = core_en_i && en_q_r && !pend_r && !buf_v_r && !halt_r && !cmd_valid_i;

    always_comb begin
        rsp_entry.is_exc        = imem_err_i;
        rsp_entry.pc            = pc_r;
        rsp_entry.payload.instr = imem_rdata_i;
        if (imem_err_i) begin
            rsp_entry.payload.exc.pad   = '0;
            rsp_entry.payload.exc.cause = cause_fetch_err_c;
        end
    end

    // Nothing is pushed while a redirect is pending
    assign fq_valid_o = !cmd_valid_i && (buf_v_r || rsp_v);
    assign fq_data_o  = buf_v_r ? buf_r : rsp_entry;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_r    <= '0;
            en_q_r  <= 1'b0;
            pend_r  <= 1'b0;
            halt_r  <= 1'b0;
            buf_v_r <= 1'b0;
        end else begin
            en_q_r <= core_en_i;
            if (cmd_take) begin
                pc_r    <= cmd_data_i.pc;
                pend_r  <= 1'b0;
                halt_r  <= 1'b0;
                buf_v_r <= 1'b0;
            end else begin
                if (imem_valid_o && imem_ready_i)
                    pend_r <= 1'b1;
                if (rsp_v) begin
                    pend_r  <= 1'b0;
                    pc_r    <= pc_r + 1'b1;
                    halt_r  <= imem_err_i;
                    buf_v_r <= !fq_ready_i;      // Queue full, park it
                end else if (buf_v_r && fq_ready_i) begin
                    buf_v_r <= 1'b0;
                end
            end
            if (core_en_i && !en_q_r)
                pc_r <= boot_pc_i;               // Enable rising edge
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_v && !fq_ready_i)
            buf_r <= rsp_entry;
    end

endmodule

`default_nettype wire

/* verilog/core_cfg_regs.sv */
// Write-only register block, no handshake; a write is visible one cycle later, all fields reset to 0
`timescale 1ns/100ps
`default_nettype none

module core_cfg_regs
    import core_pkg::*;
(
    input  logic                  clk_i
    , input  logic                rst_n_i

    , input  logic                cfg_we_i
    , input  cfg_addr_t           cfg_addr_i
    , input  logic [pc_width_c-1:0] cfg_wdata_i

    , output logic [pc_width_c-1:0] boot_pc_o
    , output logic [pc_width_c-1:0] trap_pc_o
    , output logic                core_en_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            boot_pc_o <= '0;
            trap_pc_o <= '0;
            core_en_o <= 1'b0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                cfg_boot_pc_c: boot_pc_o <= cfg_wdata_i;
                cfg_trap_pc_c: trap_pc_o <= cfg_wdata_i;
                cfg_enable_c:  core_en_o <= cfg_wdata_i[0];
                default: ;                               // Address 3 is unmapped
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
// Word addressed PCs; instruction fields are fixed and the only exception cause is a fetch error
`default_nettype none

package core_pkg;

    localparam int pc_width_c       = 16;
    localparam int instr_width_c    = 32;
    localparam int reg_addr_width_c = 3;   // Register 0 reads as zero
    localparam int reg_data_width_c = 32;
    localparam int cause_width_c    = 4;

    localparam logic [1:0] op_addi_c = 2'd0;
    localparam logic [1:0] op_jmp_c  = 2'd1;
    localparam logic [1:0] op_nop_c  = 2'd2;

    localparam logic [cause_width_c-1:0] cause_fetch_err_c = 4'd1;

    typedef struct packed {
        logic [1:0]                  op;    // 31..30
        logic [reg_addr_width_c-1:0] rd;    // 29..27
        logic [reg_addr_width_c-1:0] rs;    // 26..24
        logic [7:0]                  rsvd;
        logic [15:0]                 imm;   // Sign extended for addi, target for jmp
    } instr_t;

    typedef struct packed {
        logic [instr_width_c-cause_width_c-1:0] pad;
        logic [cause_width_c-1:0]               cause;
    } exc_word_t;

    // Queue payload is either a fetched word or an exception cause
    typedef union packed {
        instr_t    instr;
        exc_word_t exc;
    } fq_payload_u;

    typedef struct packed {
        logic                  is_exc;
        logic [pc_width_c-1:0] pc;
        fq_payload_u           payload;
    } fq_entry_t;

    // Every command is a redirect
    typedef struct packed {
        logic [pc_width_c-1:0] pc;
    } fe_cmd_t;

    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t cfg_boot_pc_c = 2'd0;
    localparam cfg_addr_t cfg_trap_pc_c = 2'd1;
    localparam cfg_addr_t cfg_enable_c  = 2'd2;   // Bit 0 of write data

endpackage

`default_nettype wire
